// File: common/beeb_config.svh
`ifndef BEEB_CONFIG_SVH
`define BEEB_CONFIG_SVH

// ==================================================
// memory geometry
// ==================================================

// address bits inside one 16 KB bank
`define BEEB_SLOT_BITS 14

// physical ROM slots behind the bank map
`define BEEB_ROM_SLOTS 16

// physical ROM address, slot plus offset
`define BEEB_ROM_ADDR_BITS 18

// cpu-side external address, top bit selects RAM
`define BEEB_BUS_ADDR_BITS 19

// ram depth, 13 banks of 16 KB
`define BEEB_RAM_BYTES 212992

// ==================================================
// mouse and sd activity
// ==================================================

// per-packet motion clamp
`define BEEB_MOUSE_STEP 10

// cycles the activity light stays on after the last toggle
`define BEEB_ACT_TIMEOUT 64

`endif

// File: common/beeb_pkg.sv
`include "beeb_config.svh"

package beeb_pkg;

	// ==================================================
	// host configuration
	// ==================================================

	// filing-system choice, in menu order
	typedef enum logic [2:0] {
		mmfs_v1,
		mmfs_v2,
		dfs,
		mmfs_v1_dfs,
		mmfs_v2_dfs
	} fs_sel_t;

	typedef struct packed {
		logic    model_m128;
		fs_sel_t fs_sel;
		logic    mouse_joy_en;
	} host_cfg_t;

	// ==================================================
	// memory side
	// ==================================================

	// rom image loader, one byte per strobe
	typedef struct packed {
		logic                             wr;
		logic [`BEEB_ROM_ADDR_BITS-1:0]   addr;
		logic [7:0]                       data;
	} rom_load_t;

	// external bus from the cpu core
	typedef struct packed {
		logic                             we_n;
		logic [`BEEB_BUS_ADDR_BITS-1:0]   addr;
		logic [7:0]                       wdata;
	} mem_req_t;

	// ==================================================
	// mouse and joystick
	// ==================================================

	// ps/2 style packet, stb flips on every new packet
	typedef struct packed {
		logic       stb;
		logic [7:0] dy;
		logic [7:0] dx;
		logic [1:0] ovf;
		logic       sign_y;
		logic       sign_x;
		logic [3:0] btn;
	} mouse_pkt_t;

	typedef struct packed {
		logic [15:0] btn;
		logic [7:0]  x;
		logic [7:0]  y;
	} joy_in_t;

	// emulator-facing analog stick
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic       fire_n;
	} axis_t;

endpackage

// File: memory/rom_bank_map.sv
`timescale 1ns/10ps

module rom_bank_map (
	input  logic                model_m128,
	input  beeb_pkg::fs_sel_t   fs_sel,
	input  logic [3:0]          bank,
	output logic [3:0]          slot,
	output logic                slot_en
);

	import beeb_pkg::*;

	logic dfs_on;
	logic mmfs_on;
	logic mmfs_v1_img;

	// filing-system decode
	// dfs rom present in the three dfs choices
	assign dfs_on = (fs_sel == dfs) || (fs_sel == mmfs_v1_dfs) || (fs_sel == mmfs_v2_dfs);
	// mmfs present in everything but plain dfs
	assign mmfs_on = (fs_sel != dfs);
	// v1 image lives in a separate slot from v2
	assign mmfs_v1_img = (fs_sel == mmfs_v1) || (fs_sel == mmfs_v1_dfs);

	// ==================================================
	// bank to slot
	// ==================================================

	always_comb begin
		slot = 4'd0;
		slot_en = 1'b0;
		case ({model_m128, bank})
			// model b
			5'b0_0011: begin
				// dfs
				slot = 4'd4;
				slot_en = dfs_on;
			end
			5'b0_0100: begin
				// os 1.2, high rom
				slot = 4'd0;
				slot_en = 1'b1;
			end
			5'b0_1000: begin
				// sideways mmfs, split rom/ram bank
				slot = mmfs_v1_img ? 4'd1 : 4'd14;
				slot_en = mmfs_on;
			end
			5'b0_1110: begin
				slot = 4'd2;
				slot_en = 1'b1;
			end
			5'b0_1111: begin
				// basic
				slot = 4'd3;
				slot_en = 1'b1;
			end
			// master
			5'b1_0011: begin
				// master mmfs
				slot = mmfs_v1_img ? 4'd5 : 4'd15;
				slot_en = mmfs_on;
			end
			5'b1_0100: begin
				// mos, high rom
				slot = 4'd6;
				slot_en = 1'b1;
			end
			5'b1_1001: begin
				// master dfs
				slot = 4'd7;
				slot_en = dfs_on;
			end
			// the rest of the master roms sit two slots below their bank
			5'b1_1010: begin
				slot = 4'd8;
				slot_en = 1'b1;
			end
			5'b1_1011: begin
				slot = 4'd9;
				slot_en = 1'b1;
			end
			5'b1_1100: begin
				slot = 4'd10;
				slot_en = 1'b1;
			end
			5'b1_1101: begin
				slot = 4'd11;
				slot_en = 1'b1;
			end
			5'b1_1110: begin
				slot = 4'd12;
				slot_en = 1'b1;
			end
			5'b1_1111: begin
				slot = 4'd13;
				slot_en = 1'b1;
			end
			default: begin
				// unmapped, reads as zero
				slot = 4'd0;
				slot_en = 1'b0;
			end
		endcase
	end

endmodule

// File: memory/paged_memory.sv
`timescale 1ns/10ps

`include "beeb_config.svh"

module paged_memory (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  beeb_pkg::fs_sel_t     fs_sel,
	input  logic                  model_m128_cfg,
	input  beeb_pkg::rom_load_t   load,
	input  beeb_pkg::mem_req_t    mem,
	output logic [7:0]            mem_rdata
);

	localparam int SLOT_BITS = `BEEB_SLOT_BITS;
	localparam int ROM_BITS  = `BEEB_ROM_ADDR_BITS;
	localparam int BUS_BITS  = `BEEB_BUS_ADDR_BITS;
	localparam int ROM_BYTES = `BEEB_ROM_SLOTS << `BEEB_SLOT_BITS;
	localparam int RAM_BYTES = `BEEB_RAM_BYTES;

	logic                model_m128;
	logic [3:0]          slot;
	logic                slot_en;
	logic [ROM_BITS-1:0] rom_addr;
	logic [7:0]          rom [ROM_BYTES];
	logic [7:0]          ram [RAM_BYTES];
	logic [7:0]          rom_dout;
	logic [7:0]          ram_dout;
	logic                we_prev;
	logic                ram_wr;
	logic                slot_en_q;
	logic                ram_sel_q;

	// model only changes while held in reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_m128 <= model_m128_cfg;
		end
	end

	// ==================================================
	// rom side
	// ==================================================

	rom_bank_map i_rom_bank_map (
		.model_m128 (model_m128),
		.fs_sel     (fs_sel),
		.bank       (mem.addr[SLOT_BITS+3:SLOT_BITS]),
		.slot       (slot),
		.slot_en    (slot_en)
	);

	assign rom_addr = {slot, mem.addr[SLOT_BITS-1:0]};

	// loader port, only live during reset
	always_ff @(posedge clk_sys) begin
		if (reset && load.wr) begin
			rom[load.addr] <= load.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		rom_dout <= rom[rom_addr];
	end

	// ==================================================
	// ram side
	// ==================================================

	// write once on the falling edge of we_n
	assign ram_wr = we_prev && !mem.we_n && mem.addr[BUS_BITS-1]
		&& (mem.addr[ROM_BITS-1:0] < RAM_BYTES);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			we_prev <= 1'b1;
		end else begin
			we_prev <= mem.we_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_wr) begin
			ram[mem.addr[ROM_BITS-1:0]] <= mem.wdata;
		end
		ram_dout <= ram[mem.addr[ROM_BITS-1:0]];
	end

	// ==================================================
	// read mux
	// ==================================================

	// select bits follow the data through the read register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			slot_en_q <= 1'b0;
			ram_sel_q <= 1'b0;
		end else begin
			slot_en_q <= slot_en;
			ram_sel_q <= mem.addr[BUS_BITS-1];
		end
	end

	// disabled slot reads back zero
	assign mem_rdata = ram_sel_q ? ram_dout : (slot_en_q ? rom_dout : 8'h00);

	// loader must never overwrite rom while the cpu is running
	a_load_in_reset : assert property (@(posedge clk_sys) load.wr |-> reset);

endmodule

// File: hdl/mouse_joystick.sv
`timescale 1ns/10ps

`include "beeb_config.svh"

module mouse_joystick (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   enable,
	input  beeb_pkg::mouse_pkt_t   mouse,
	input  beeb_pkg::joy_in_t      joy,
	output beeb_pkg::axis_t        axis
);

	localparam logic signed [8:0] step_max = `BEEB_MOUSE_STEP;
	localparam logic signed [8:0] pos_max  = 9'sd127;
	localparam logic signed [8:0] pos_min  = -9'sd128;

	logic              stb_prev;
	logic              emu;
	logic signed [8:0] mx;
	logic signed [8:0] my;
	logic signed [8:0] mdx;
	logic signed [8:0] mdy;
	logic signed [8:0] mdx_c;
	logic signed [8:0] mdy_c;
	logic signed [8:0] nmx;
	logic signed [8:0] nmy;
	logic              leave_emu;

	// ==================================================
	// motion
	// ==================================================

	// sign bit plus 8-bit magnitude field
	assign mdx = {mouse.sign_x, mouse.dx};
	assign mdy = {mouse.sign_y, mouse.dy};

	// clamp to one step per packet
	assign mdx_c = (mdx > step_max) ? step_max : (mdx < -step_max) ? -step_max : mdx;
	assign mdy_c = (mdy > step_max) ? step_max : (mdy < -step_max) ? -step_max : mdy;

	// screen y grows downward but stick y grows upward
	assign nmx = mx + mdx_c;
	assign nmy = my - mdy_c;

	// real pad use or menu off drops back to pass-through
	assign leave_emu = reset || !enable || (|joy.btn);

	always_ff @(posedge clk_sys) begin
		stb_prev <= mouse.stb;
		if (leave_emu) begin
			emu <= 1'b0;
			mx <= '0;
			my <= '0;
		end else if (stb_prev != mouse.stb) begin
			emu <= 1'b1;
			// saturate to signed byte range
			mx <= (nmx < pos_min) ? pos_min : (nmx > pos_max) ? pos_max : nmx;
			my <= (nmy < pos_min) ? pos_min : (nmy > pos_max) ? pos_max : nmy;
		end
	end

	// ==================================================
	// output
	// ==================================================

	// signed position inverted onto the byte scale around 127
	always_comb begin
		if (emu) begin
			axis.x = 8'd127 - mx[7:0];
			axis.y = 8'd127 - my[7:0];
			axis.fire_n = !(|mouse.btn[1:0]);
		end else begin
			axis.x = 8'd127 - joy.x;
			axis.y = 8'd127 - joy.y;
			axis.fire_n = !joy.btn[4];
		end
	end

	// accumulated position never escapes the byte range
	a_pos_range : assert property (@(posedge clk_sys) disable iff (reset)
		(mx >= pos_min) && (mx <= pos_max) && (my >= pos_min) && (my <= pos_max));

endmodule

// File: hdl/activity_timer.sv
`timescale 1ns/10ps

`include "beeb_config.svh"

module activity_timer (
	input  logic clk_sys,
	input  logic reset,
	input  logic mosi,
	input  logic miso,
	output logic active
);

	localparam int timeout = `BEEB_ACT_TIMEOUT;
	localparam int cw      = $clog2(timeout + 1);

	logic          mosi_prev;
	logic          miso_prev;
	logic          toggle;
	logic [cw-1:0] count;

	// edge history of both spi data lines
	always_ff @(posedge clk_sys) begin
		mosi_prev <= mosi;
		miso_prev <= miso;
	end

	assign toggle = (mosi_prev ^ mosi) || (miso_prev ^ miso);

	// ==================================================
	// retriggerable count
	// ==================================================

	// parks at the timeout with the light off
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= cw'(timeout);
		end else if (toggle) begin
			count <= '0;
		end else if (count < cw'(timeout)) begin
			count <= count + 1'b1;
		end
	end

	assign active = (count < cw'(timeout));

	// count parks at the timeout and never runs past it
	a_count_bound : assert property (@(posedge clk_sys) disable iff (reset)
		count <= cw'(timeout));

endmodule

// File: hdl/beeb_host_top.sv
`timescale 1ns/10ps

module beeb_host_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  beeb_pkg::host_cfg_t    cfg,
	input  beeb_pkg::rom_load_t    load,
	input  beeb_pkg::mem_req_t     mem,
	output logic [7:0]             mem_rdata,
	input  beeb_pkg::mouse_pkt_t   mouse,
	input  beeb_pkg::joy_in_t      joy,
	output beeb_pkg::axis_t        axis,
	input  logic                   spi_mosi,
	input  logic                   spi_miso,
	output logic                   sd_activity
);

	// ==================================================
	// paged rom and ram
	// ==================================================

	// model is latched inside while reset is held
	paged_memory i_paged_memory (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.fs_sel         (cfg.fs_sel),
		.model_m128_cfg (cfg.model_m128),
		.load           (load),
		.mem            (mem),
		.mem_rdata      (mem_rdata)
	);

	// ==================================================
	// analog stick
	// ==================================================

	// mouse drives the stick unless the real pad is touched
	mouse_joystick i_mouse_joystick (
		.clk_sys (clk_sys),
		.reset   (reset),
		.enable  (cfg.mouse_joy_en),
		.mouse   (mouse),
		.joy     (joy),
		.axis    (axis)
	);

	// ==================================================
	// sd activity light
	// ==================================================

	activity_timer i_activity_timer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mosi    (spi_mosi),
		.miso    (spi_miso),
		.active  (sd_activity)
	);

endmodule

// File: bench/beeb_host_tb.sv
`timescale 1ns/10ps

`include "beeb_config.svh"

module beeb_host_tb;

	import beeb_pkg::*;

	// test lengths come to well under 1500 cycles, limit leaves headroom
	localparam int CYCLE_LIMIT = 4000;
	localparam int STEP        = `BEEB_MOUSE_STEP;
	localparam int TIMEOUT     = `BEEB_ACT_TIMEOUT;

	logic       clk_sys;
	logic       reset;
	host_cfg_t  cfg;
	rom_load_t  load;
	mem_req_t   mem;
	logic [7:0] mem_rdata;
	mouse_pkt_t mouse;
	joy_in_t    joy;
	axis_t      axis;
	logic       spi_mosi;
	logic       spi_miso;
	logic       sd_activity;

	integer seed = 39;
	int     cycles = 0;
	int     errors = 0;
	int     test_errs = 0;
	int     tests_run = 0;
	int     tests_failed = 0;

	// tracked mouse state
	logic   t_emu;
	int     t_mx;
	int     t_my;

	beeb_host_top i_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cfg         (cfg),
		.load        (load),
		.mem         (mem),
		.mem_rdata   (mem_rdata),
		.mouse       (mouse),
		.joy         (joy),
		.axis        (axis),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.sd_activity (sd_activity)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles without reaching the end", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// ==================================================
	// reference model
	// ==================================================

	// expected physical slot for a cpu bank
	function automatic logic [3:0] ref_slot(input logic m128, input fs_sel_t fs,
		input logic [3:0] bank);
		logic v1;
		v1 = (fs == mmfs_v1) || (fs == mmfs_v1_dfs);
		if (!m128) begin
			case (bank)
				4'd3: return 4'd4;
				4'd8: return v1 ? 4'd1 : 4'd14;
				4'd14: return 4'd2;
				4'd15: return 4'd3;
				default: return 4'd0;
			endcase
		end
		if (bank == 4'd3)
			return v1 ? 4'd5 : 4'd15;
		if (bank == 4'd4)
			return 4'd6;
		if (bank >= 4'd9)
			return bank - 4'd2;
		return 4'd0;
	endfunction

	// whether the bank returns data at all
	function automatic logic ref_enable(input logic m128, input fs_sel_t fs,
		input logic [3:0] bank);
		logic dfs_fs;
		dfs_fs = (fs == dfs) || (fs == mmfs_v1_dfs) || (fs == mmfs_v2_dfs);
		if (!m128) begin
			case (bank)
				4'd3: return dfs_fs;
				4'd8: return fs != dfs;
				4'd4, 4'd14, 4'd15: return 1'b1;
				default: return 1'b0;
			endcase
		end
		if (bank == 4'd3)
			return fs != dfs;
		if (bank == 4'd9)
			return dfs_fs;
		return (bank == 4'd4) || (bank >= 4'd10);
	endfunction

	// emulated stick, or pass-through of the real one
	function automatic axis_t ref_axis(input logic emu, input int px, input int py,
		input logic [3:0] mbtn, input joy_in_t j);
		axis_t a;
		if (emu) begin
			a.x = 8'(127 - px);
			a.y = 8'(127 - py);
			a.fire_n = !(mbtn[0] || mbtn[1]);
		end else begin
			a.x = 8'(127 - int'(j.x));
			a.y = 8'(127 - int'(j.y));
			a.fire_n = !j.btn[4];
		end
		return a;
	endfunction

	// sign plus magnitude field, clamped to one step
	function automatic int step_of(input logic sgn, input logic [7:0] mag);
		int v;
		v = sgn ? int'(mag) - 256 : int'(mag);
		if (v > STEP)
			return STEP;
		if (v < -STEP)
			return -STEP;
		return v;
	endfunction

	function automatic int sat_byte(input int v);
		if (v > 127)
			return 127;
		if (v < -128)
			return -128;
		return v;
	endfunction

	// ==================================================
	// helpers
	// ==================================================

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %s: %0s, %0d mismatches", name, (test_errs == 0) ? "ok" : "bad", test_errs);
		test_errs = 0;
	endtask

	// reset stays high on return
	task automatic hold_reset(input logic m128);
		@(posedge clk_sys);
		#1;
		reset = 1'b1;
		cfg.model_m128 = m128;
		repeat (16) @(posedge clk_sys);
	endtask

	task automatic release_reset();
		@(posedge clk_sys);
		#1;
		reset = 1'b0;
	endtask

	// 16 bytes per slot, byte = slot*16 + low nibble
	task automatic load_rom();
		for (int s = 0; s < 16; s++) begin
			for (int o = 0; o < 16; o++) begin
				@(posedge clk_sys);
				#1;
				load.wr = 1'b1;
				load.addr = {4'(s), 14'(o)};
				load.data = {4'(s), 4'(o)};
			end
		end
		@(posedge clk_sys);
		#1;
		load.wr = 1'b0;
	endtask

	// one bank read, data checked one cycle later
	task automatic read_bank(input logic [3:0] bank);
		logic [3:0] off;
		logic [7:0] exp;
		off = 4'($random(seed));
		exp = ref_enable(cfg.model_m128, cfg.fs_sel, bank)
			? {ref_slot(cfg.model_m128, cfg.fs_sel, bank), off} : 8'h00;
		@(posedge clk_sys);
		#1;
		mem.addr = {1'b0, bank, 10'h000, off};
		@(posedge clk_sys);
		#1;
		check("mem_rdata", 32'(mem_rdata), 32'(exp));
	endtask

	task automatic fs_banks(input logic m128);
		for (int k = 0; k < 5; k++) begin
			@(posedge clk_sys);
			#1;
			cfg.fs_sel = fs_sel_t'(k);
			read_bank(4'd3);
			read_bank(m128 ? 4'd9 : 4'd8);
		end
	endtask

	// flip stb with a new motion report, then compare axis
	task automatic send_packet(input logic sx, input logic sy);
		@(posedge clk_sys);
		#1;
		mouse.stb = ~mouse.stb;
		mouse.dx = 8'($random(seed));
		mouse.dy = 8'($random(seed));
		mouse.ovf = 2'($random(seed));
		mouse.btn = 4'($random(seed));
		mouse.sign_x = sx;
		mouse.sign_y = sy;
		if (cfg.mouse_joy_en && (joy.btn == 16'h0)) begin
			t_emu = 1'b1;
			t_mx = sat_byte(t_mx + step_of(sx, mouse.dx));
			t_my = sat_byte(t_my - step_of(sy, mouse.dy));
		end
		@(posedge clk_sys);
		#1;
		check("axis", 32'(axis), 32'(ref_axis(t_emu, t_mx, t_my, mouse.btn, joy)));
	endtask

	task automatic expect_passthrough();
		@(posedge clk_sys);
		#1;
		t_emu = 1'b0;
		t_mx = 0;
		t_my = 0;
		check("axis", 32'(axis), 32'(ref_axis(1'b0, 0, 0, mouse.btn, joy)));
	endtask

	// length of the active run after a mosi toggle, optional miso retrigger
	task automatic measure_active(input int retrig_at, output int n);
		n = 0;
		@(posedge clk_sys);
		#1;
		spi_mosi = ~spi_mosi;
		while (n < 300) begin
			@(posedge clk_sys);
			#1;
			if (!sd_activity)
				break;
			n++;
			if (n == retrig_at)
				spi_miso = ~spi_miso;
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		int n;
		reset = 1'b1;
		cfg = '{model_m128: 1'b0, fs_sel: mmfs_v1_dfs, mouse_joy_en: 1'b1};
		load = '0;
		mem = '{we_n: 1'b1, addr: '0, wdata: '0};
		mouse = '0;
		joy = '0;
		spi_mosi = 1'b0;
		spi_miso = 1'b0;
		t_emu = 1'b0;
		t_mx = 0;
		t_my = 0;

		// rom mapping, model b then master
		hold_reset(1'b0);
		load_rom();
		release_reset();
		for (int b = 0; b < 16; b++)
			read_bank(4'(b));
		hold_reset(1'b1);
		release_reset();
		for (int b = 0; b < 16; b++)
			read_bank(4'(b));
		end_test("rom_mapping");

		// filing-system enables
		hold_reset(1'b0);
		release_reset();
		fs_banks(1'b0);
		hold_reset(1'b1);
		release_reset();
		fs_banks(1'b1);
		end_test("fs_enables");

		// ram writes, holding we_n low must not write again
		for (int i = 0; i < 8; i++) begin
			logic [17:0] a;
			logic [7:0]  d;
			a = 18'({$random(seed)} % `BEEB_RAM_BYTES);
			d = 8'($random(seed));
			@(posedge clk_sys);
			#1;
			mem = '{we_n: 1'b0, addr: {1'b1, a}, wdata: d};
			@(posedge clk_sys);
			#1;
			mem.wdata = ~d;
			@(posedge clk_sys);
			#1;
			mem.we_n = 1'b1;
			@(posedge clk_sys);
			#1;
			check("mem_rdata", 32'(mem_rdata), 32'(d));
		end
		end_test("ram_write_edge");

		// push both axes into the top, then the bottom, then wander
		for (int i = 0; i < 16; i++)
			send_packet(1'b0, 1'b1);
		for (int i = 0; i < 32; i++)
			send_packet(1'b1, 1'b0);
		for (int i = 0; i < 16; i++)
			send_packet(1'($random(seed)), 1'($random(seed)));
		end_test("mouse_clamp");

		// real button press takes the stick back
		@(posedge clk_sys);
		#1;
		joy = '{btn: 16'h0010, x: 8'($random(seed)), y: 8'($random(seed))};
		expect_passthrough();
		joy.btn = 16'h0;
		expect_passthrough();
		send_packet(1'($random(seed)), 1'($random(seed)));
		// menu switch off does the same
		cfg.mouse_joy_en = 1'b0;
		expect_passthrough();
		cfg.mouse_joy_en = 1'b1;
		send_packet(1'($random(seed)), 1'($random(seed)));
		end_test("joystick_takeover");

		// sd activity light
		hold_reset(1'b0);
		release_reset();
		@(posedge clk_sys);
		#1;
		check("sd_activity", 32'(sd_activity), 32'h0);
		measure_active(0, n);
		check("active_cycles", n, TIMEOUT);
		measure_active(20, n);
		check("active_cycles", n, 20 + TIMEOUT);
		end_test("activity_timer");

		$display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: beeb_host.f
+incdir+common
common/beeb_pkg.sv
memory/rom_bank_map.sv
memory/paged_memory.sv
hdl/mouse_joystick.sv
hdl/activity_timer.sv
hdl/beeb_host_top.sv
bench/beeb_host_tb.sv
